//--- flist.f
hw/acc_pkg.sv
hw/acc_ctrl_regs.sv
hw/acc_scale_engine.sv
hw/acc_reduce_engine.sv
hw/acc_mem_arbiter.sv
hw/acc_subsystem.sv
testbench/tb_acc_checker.sv
testbench/tb_acc_subsystem.sv

//--- hw/acc_ctrl_regs.sv
////////////////////////////////////////
// Engine configuration registers
// Four-phase ack side, job setup and start pulse
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module acc_ctrl_regs #(
  parameter int unsigned LEN_W = 8
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              cfg_req_i,
  input  acc_pkg::cfg_req_t cfg_i,
  output logic              cfg_ack_o,
  output acc_pkg::cfg_rsp_t cfg_rsp_o,
  input  logic              busy_i,
  output logic              start_o,
  output acc_pkg::acc_cfg_t regs_o,
  output logic [LEN_W-1:0]  len_o
);

  logic                       ack_q;
  logic                       req_new;
  logic                       wr_en;
  logic [acc_pkg::DATA_W-1:0] rdata_d;
  logic [acc_pkg::DATA_W-1:0] rdata_q;
  acc_pkg::acc_cfg_t          regs_q;
  logic [LEN_W-1:0]           len_q;

  // Request seen, ack goes up at the next edge
  assign req_new = cfg_req_i && !ack_q;
  assign wr_en   = req_new && cfg_i.wen && !busy_i;
  assign start_o = wr_en && (cfg_i.addr == acc_pkg::REG_CTRL);

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= cfg_req_i;
    end
  end

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      regs_q <= '0;
      len_q  <= '0;
    end else if (wr_en) begin
      case (cfg_i.addr)
        acc_pkg::REG_SRC:   regs_q.src   <= cfg_i.wdata[acc_pkg::ADDR_W-1:0];
        acc_pkg::REG_DST:   regs_q.dst   <= cfg_i.wdata[acc_pkg::ADDR_W-1:0];
        acc_pkg::REG_LEN:   len_q        <= cfg_i.wdata[LEN_W-1:0];
        acc_pkg::REG_PARAM: regs_q.param <= cfg_i.wdata;
        default: ;
      endcase
    end
  end

  // Readback, zero for unmapped slots
  always_comb begin
    rdata_d = '0;
    case (cfg_i.addr)
      acc_pkg::REG_SRC:   rdata_d[acc_pkg::ADDR_W-1:0] = regs_q.src;
      acc_pkg::REG_DST:   rdata_d[acc_pkg::ADDR_W-1:0] = regs_q.dst;
      acc_pkg::REG_LEN:   rdata_d[LEN_W-1:0]           = len_q;
      acc_pkg::REG_PARAM: rdata_d                      = regs_q.param;
      acc_pkg::REG_CTRL:  rdata_d[0]                   = busy_i;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_new) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg_ack_o       = ack_q;
  assign cfg_rsp_o.rdata = rdata_q;
  assign regs_o          = regs_q;
  assign len_o           = len_q;

  // No new request from the host while ack is still high
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cfg_ack_o |-> !$rose(cfg_req_i));

endmodule

`default_nettype wire

//--- hw/acc_mem_arbiter.sv
////////////////////////////////////////
// Memory port arbiter
// Round-robin, grant locked per four-phase cycle
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module acc_mem_arbiter (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [1:0]              req_i,
  input  acc_pkg::mem_req_t [1:0] in_i,
  output logic [1:0]              ack_o,
  output acc_pkg::mem_rsp_t       rsp_o,
  output logic                    mem_req_o,
  output acc_pkg::mem_req_t       mem_o,
  input  logic                    mem_ack_i,
  input  acc_pkg::mem_rsp_t       mem_i
);

  logic lock_q;
  logic owner_q;
  logic prio_q;
  logic pick;

  // Preferred engine wins a tie
  assign pick = req_i[prio_q] ? prio_q : ~prio_q;

  ////////////////////////////////////////
  // Grant and release
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q  <= 1'b0;
      owner_q <= 1'b0;
      prio_q  <= 1'b0;
    end else if (!lock_q) begin
      if (|req_i) begin
        lock_q  <= 1'b1;
        owner_q <= pick;
      end
    end else if (!req_i[owner_q] && !mem_ack_i) begin
      // Cycle complete, other side goes first next time
      lock_q <= 1'b0;
      prio_q <= ~owner_q;
    end
  end

  assign mem_req_o = lock_q && req_i[owner_q];
  assign mem_o     = in_i[owner_q];

  // Only the owner sees ack and data
  always_comb begin
    ack_o = '0;
    if (lock_q) begin
      ack_o[owner_q] = mem_ack_i;
    end
  end

  assign rsp_o.rdata = lock_q ? mem_i.rdata : '0;

  // Memory answers only inside a granted cycle
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_ack_i |-> lock_q);

endmodule

`default_nettype wire

//--- hw/acc_pkg.sv
////////////////////////////////////////
// Accelerator shared definitions
// Bus widths, handshake structs and FSM encodings
////////////////////////////////////////

`default_nettype none

package acc_pkg;

  // Bus widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 16;

  // Configuration register index
  typedef enum logic [2:0] {
    REG_SRC   = 3'd0,
    REG_DST   = 3'd1,
    REG_LEN   = 3'd2,
    REG_PARAM = 3'd3,
    REG_CTRL  = 3'd4
  } acc_reg_e;

  typedef struct packed {
    acc_reg_e          addr;
    logic              wen;
    logic [DATA_W-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } cfg_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              wen;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_READ_REL,
    ST_WRITE,
    ST_WRITE_REL,
    ST_DONE
  } eng_state_e;

  // Job setup, fixed-width part; the length travels beside it
  typedef struct packed {
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
    logic [DATA_W-1:0] param;
  } acc_cfg_t;

endpackage

`default_nettype wire

//--- hw/acc_reduce_engine.sv
////////////////////////////////////////
// Reduce engine
// Sums len words from src onto param, writes one word to dst
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module acc_reduce_engine #(
  parameter int unsigned LEN_W = 8
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              cfg_req_i,
  input  acc_pkg::cfg_req_t cfg_i,
  output logic              cfg_ack_o,
  output acc_pkg::cfg_rsp_t cfg_rsp_o,
  output logic              mem_req_o,
  output acc_pkg::mem_req_t mem_o,
  input  logic              mem_ack_i,
  input  acc_pkg::mem_rsp_t mem_i,
  output logic              busy_o,
  output logic              evt_o
);

  localparam int unsigned AW = acc_pkg::ADDR_W;

  acc_pkg::eng_state_e        state_q;
  acc_pkg::acc_cfg_t          regs;
  logic [LEN_W-1:0]           len;
  logic [LEN_W-1:0]           idx_q;
  logic [acc_pkg::DATA_W-1:0] acc_q;
  logic                       start;
  logic                       last;

  acc_ctrl_regs #(
    .LEN_W ( LEN_W )
  ) ctrl_regs_inst (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .cfg_req_i ( cfg_req_i ),
    .cfg_i     ( cfg_i     ),
    .cfg_ack_o ( cfg_ack_o ),
    .cfg_rsp_o ( cfg_rsp_o ),
    .busy_i    ( busy_o    ),
    .start_o   ( start     ),
    .regs_o    ( regs      ),
    .len_o     ( len       )
  );

  assign last = ({1'b0, idx_q} + 1'b1) >= {1'b0, len};

  ////////////////////////////////////////
  // Read loop, then one write
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= acc_pkg::ST_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        acc_pkg::ST_IDLE, acc_pkg::ST_DONE: begin
          if (start) begin
            idx_q   <= '0;
            // Nothing to read or write for len 0
            state_q <= (len == '0) ? acc_pkg::ST_WRITE_REL : acc_pkg::ST_READ;
          end else begin
            state_q <= acc_pkg::ST_IDLE;
          end
        end
        acc_pkg::ST_READ: begin
          if (mem_ack_i) state_q <= acc_pkg::ST_READ_REL;
        end
        acc_pkg::ST_READ_REL: begin
          if (!mem_ack_i) begin
            if (last) begin
              state_q <= acc_pkg::ST_WRITE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= acc_pkg::ST_READ;
            end
          end
        end
        acc_pkg::ST_WRITE: begin
          if (mem_ack_i) state_q <= acc_pkg::ST_WRITE_REL;
        end
        acc_pkg::ST_WRITE_REL: begin
          if (!mem_ack_i) state_q <= acc_pkg::ST_DONE;
        end
        default: state_q <= acc_pkg::ST_IDLE;
      endcase
    end
  end

  // Accumulator wraps modulo 2^32
  always_ff @(posedge clk_i) begin
    if (start) begin
      acc_q <= regs.param;
    end else if (state_q == acc_pkg::ST_READ && mem_ack_i) begin
      acc_q <= acc_q + mem_i.rdata;
    end
  end

  assign mem_req_o   = (state_q == acc_pkg::ST_READ) || (state_q == acc_pkg::ST_WRITE);
  assign mem_o.wen   = (state_q == acc_pkg::ST_WRITE);
  assign mem_o.addr  = mem_o.wen ? regs.dst : regs.src + AW'(idx_q);
  assign mem_o.wdata = acc_q;

  assign busy_o = (state_q != acc_pkg::ST_IDLE) && (state_q != acc_pkg::ST_DONE);
  assign evt_o  = (state_q == acc_pkg::ST_DONE);

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_o));

endmodule

`default_nettype wire

//--- hw/acc_scale_engine.sv
////////////////////////////////////////
// Scale engine
// dst[i] = src[i] * param for each i below len
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module acc_scale_engine #(
  parameter int unsigned LEN_W = 8
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              cfg_req_i,
  input  acc_pkg::cfg_req_t cfg_i,
  output logic              cfg_ack_o,
  output acc_pkg::cfg_rsp_t cfg_rsp_o,
  output logic              mem_req_o,
  output acc_pkg::mem_req_t mem_o,
  input  logic              mem_ack_i,
  input  acc_pkg::mem_rsp_t mem_i,
  output logic              busy_o,
  output logic              evt_o
);

  localparam int unsigned AW = acc_pkg::ADDR_W;

  acc_pkg::eng_state_e        state_q;
  acc_pkg::acc_cfg_t          regs;
  logic [LEN_W-1:0]           len;
  logic [LEN_W-1:0]           idx_q;
  logic [acc_pkg::DATA_W-1:0] prod_q;
  logic                       start;
  logic                       last;

  acc_ctrl_regs #(
    .LEN_W ( LEN_W )
  ) ctrl_regs_inst (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .cfg_req_i ( cfg_req_i ),
    .cfg_i     ( cfg_i     ),
    .cfg_ack_o ( cfg_ack_o ),
    .cfg_rsp_o ( cfg_rsp_o ),
    .busy_i    ( busy_o    ),
    .start_o   ( start     ),
    .regs_o    ( regs      ),
    .len_o     ( len       )
  );

  // Also true for an empty job
  assign last = ({1'b0, idx_q} + 1'b1) >= {1'b0, len};

  ////////////////////////////////////////
  // Element FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= acc_pkg::ST_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        acc_pkg::ST_IDLE, acc_pkg::ST_DONE: begin
          if (start) begin
            idx_q   <= '0;
            // Empty job drains straight through the release state
            state_q <= (len == '0) ? acc_pkg::ST_WRITE_REL : acc_pkg::ST_READ;
          end else begin
            state_q <= acc_pkg::ST_IDLE;
          end
        end
        acc_pkg::ST_READ: begin
          if (mem_ack_i) state_q <= acc_pkg::ST_READ_REL;
        end
        acc_pkg::ST_READ_REL: begin
          if (!mem_ack_i) state_q <= acc_pkg::ST_WRITE;
        end
        acc_pkg::ST_WRITE: begin
          if (mem_ack_i) state_q <= acc_pkg::ST_WRITE_REL;
        end
        acc_pkg::ST_WRITE_REL: begin
          if (!mem_ack_i) begin
            if (last) begin
              state_q <= acc_pkg::ST_DONE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= acc_pkg::ST_READ;
            end
          end
        end
        default: state_q <= acc_pkg::ST_IDLE;
      endcase
    end
  end

  // Low 32 bits of the product
  always_ff @(posedge clk_i) begin
    if (state_q == acc_pkg::ST_READ && mem_ack_i) begin
      prod_q <= mem_i.rdata * regs.param;
    end
  end

  assign mem_req_o   = (state_q == acc_pkg::ST_READ) || (state_q == acc_pkg::ST_WRITE);
  assign mem_o.wen   = (state_q == acc_pkg::ST_WRITE);
  assign mem_o.addr  = (mem_o.wen ? regs.dst : regs.src) + AW'(idx_q);
  assign mem_o.wdata = prod_q;

  assign busy_o = (state_q != acc_pkg::ST_IDLE) && (state_q != acc_pkg::ST_DONE);
  assign evt_o  = (state_q == acc_pkg::ST_DONE);

  // Request and payload hold until the memory answers
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_o));

endmodule

`default_nettype wire

//--- hw/acc_subsystem.sv
////////////////////////////////////////
// Accelerator subsystem top
// Two engines, config steering and shared memory port
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module acc_subsystem #(
  parameter int unsigned LEN_W = 8
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              sel_i,
  input  logic              cfg_req_i,
  input  acc_pkg::cfg_req_t cfg_i,
  output logic              cfg_ack_o,
  output acc_pkg::cfg_rsp_t cfg_rsp_o,
  output logic              mem_req_o,
  output acc_pkg::mem_req_t mem_o,
  input  logic              mem_ack_i,
  input  acc_pkg::mem_rsp_t mem_i,
  output logic              busy_o,
  output logic              evt_o
);

  logic [1:0]              eng_cfg_req;
  logic [1:0]              eng_cfg_ack;
  acc_pkg::cfg_rsp_t [1:0] eng_cfg_rsp;
  logic [1:0]              eng_mem_req;
  logic [1:0]              eng_mem_ack;
  acc_pkg::mem_req_t [1:0] eng_mem;
  acc_pkg::mem_rsp_t       eng_mem_rsp;
  logic [1:0]              eng_busy;
  logic [1:0]              eng_evt;

  ////////////////////////////////////////
  // Config steering and output select
  ////////////////////////////////////////

  // Payload goes to both, req only to the chosen one
  assign eng_cfg_req[0] = cfg_req_i && !sel_i;
  assign eng_cfg_req[1] = cfg_req_i && sel_i;

  assign cfg_ack_o = eng_cfg_ack[sel_i];
  assign cfg_rsp_o = eng_cfg_rsp[sel_i];
  assign busy_o    = eng_busy[sel_i];
  assign evt_o     = eng_evt[sel_i];

  ////////////////////////////////////////
  // Engines
  ////////////////////////////////////////

  acc_scale_engine #(
    .LEN_W ( LEN_W )
  ) scale_engine_inst (
    .clk_i     ( clk_i          ),
    .arst_n_i  ( arst_n_i       ),
    .cfg_req_i ( eng_cfg_req[0] ),
    .cfg_i     ( cfg_i          ),
    .cfg_ack_o ( eng_cfg_ack[0] ),
    .cfg_rsp_o ( eng_cfg_rsp[0] ),
    .mem_req_o ( eng_mem_req[0] ),
    .mem_o     ( eng_mem[0]     ),
    .mem_ack_i ( eng_mem_ack[0] ),
    .mem_i     ( eng_mem_rsp    ),
    .busy_o    ( eng_busy[0]    ),
    .evt_o     ( eng_evt[0]     )
  );

  acc_reduce_engine #(
    .LEN_W ( LEN_W )
  ) reduce_engine_inst (
    .clk_i     ( clk_i          ),
    .arst_n_i  ( arst_n_i       ),
    .cfg_req_i ( eng_cfg_req[1] ),
    .cfg_i     ( cfg_i          ),
    .cfg_ack_o ( eng_cfg_ack[1] ),
    .cfg_rsp_o ( eng_cfg_rsp[1] ),
    .mem_req_o ( eng_mem_req[1] ),
    .mem_o     ( eng_mem[1]     ),
    .mem_ack_i ( eng_mem_ack[1] ),
    .mem_i     ( eng_mem_rsp    ),
    .busy_o    ( eng_busy[1]    ),
    .evt_o     ( eng_evt[1]     )
  );

  // Shared memory master port
  acc_mem_arbiter mem_arbiter_inst (
    .clk_i     ( clk_i       ),
    .arst_n_i  ( arst_n_i    ),
    .req_i     ( eng_mem_req ),
    .in_i      ( eng_mem     ),
    .ack_o     ( eng_mem_ack ),
    .rsp_o     ( eng_mem_rsp ),
    .mem_req_o ( mem_req_o   ),
    .mem_o     ( mem_o       ),
    .mem_ack_i ( mem_ack_i   ),
    .mem_i     ( mem_i       )
  );

endmodule

`default_nettype wire

//--- testbench/tb_acc_checker.sv
////////////////////////////////////////
// Subsystem checker
// Matches memory writes per engine, counts events and errors
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_acc_checker (
  input  logic              clk_i,
  input  logic              mem_req_i,
  input  acc_pkg::mem_req_t mem_i,
  input  logic              mem_ack_i,
  input  logic [1:0]        eng_ack_i,
  input  logic [1:0]        eng_evt_i,
  input  logic              evt_i,
  output int                err_cnt_o,
  output int                evt0_cnt_o,
  output int                evt1_cnt_o
);

  // Expected writes, {addr, data}, oldest first
  logic [47:0] exp0_q[$];
  logic [47:0] exp1_q[$];
  int          sel_evt_cnt;

  initial begin
    err_cnt_o   = 0;
    evt0_cnt_o  = 0;
    evt1_cnt_o  = 0;
    sel_evt_cnt = 0;
  end

  task automatic expect_write(input logic eng, input logic [15:0] addr,
                              input logic [31:0] data);
    if (eng) begin
      exp1_q.push_back({addr, data});
    end else begin
      exp0_q.push_back({addr, data});
    end
  endtask

  task automatic compare(input string name, input logic [31:0] got_v,
                         input logic [31:0] want_v);
    if (got_v !== want_v) begin
      $display("FAILED %s: got %h, expected %h", name, got_v, want_v);
      err_cnt_o++;
    end
  endtask

  task automatic match_write(input logic eng);
    logic [47:0] want;
    if ((eng ? exp1_q.size() : exp0_q.size()) == 0) begin
      $display("engine %0d wrote %h to address %h where no write was expected",
               eng, mem_i.wdata, mem_i.addr);
      err_cnt_o++;
      return;
    end
    if (eng) begin
      want = exp1_q.pop_front();
    end else begin
      want = exp0_q.pop_front();
    end
    compare("mem_o.addr", 32'(mem_i.addr), 32'(want[47:32]));
    compare("mem_o.wdata", mem_i.wdata, want[31:0]);
  endtask

  ////////////////////////////////////////
  // Mid-cycle watch of the memory port
  ////////////////////////////////////////

  // req and ack both high for exactly one edge per access
  always @(negedge clk_i) begin
    if (mem_req_i && mem_ack_i && mem_i.wen) begin
      match_write(eng_ack_i[1]);
    end
    if (eng_evt_i[0]) evt0_cnt_o++;
    if (eng_evt_i[1]) evt1_cnt_o++;
    if (evt_i) sel_evt_cnt++;
  end

  task automatic clear_events();
    evt0_cnt_o  = 0;
    evt1_cnt_o  = 0;
    sel_evt_cnt = 0;
  endtask

  task automatic check_events(input int want0, input int want1, input int want_sel);
    if (evt0_cnt_o != want0 || evt1_cnt_o != want1) begin
      $display("engine events were %0d and %0d, expected %0d and %0d",
               evt0_cnt_o, evt1_cnt_o, want0, want1);
      err_cnt_o++;
    end
    if (sel_evt_cnt != want_sel) begin
      $display("evt_o pulsed %0d times for the selected engine, expected %0d",
               sel_evt_cnt, want_sel);
      err_cnt_o++;
    end
  endtask

  task automatic check_drained();
    if (exp0_q.size() != 0 || exp1_q.size() != 0) begin
      $display("writes missing at the end of the job: %0d for engine 0, %0d for engine 1",
               exp0_q.size(), exp1_q.size());
      err_cnt_o++;
    end
    exp0_q.delete();
    exp1_q.delete();
  endtask

endmodule

`default_nettype wire

//--- testbench/tb_acc_subsystem.sv
////////////////////////////////////////
// Accelerator subsystem testbench
// Memory model, job table and config sequencing
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_acc_subsystem;

  localparam int unsigned LEN_W       = 8;
  localparam int          CLK_PERIOD  = 40;
  localparam int          DRIVE_DLY   = 2;
  localparam int          CFG_TIMEOUT = 20;
  localparam int          RUN_TIMEOUT = 2000;
  localparam int          NUM_TESTS   = 6;

  typedef struct packed {
    logic             sel;
    logic [15:0]      src;
    logic [15:0]      dst;
    logic [LEN_W-1:0] len;
    logic [31:0]      param;
    logic             dual;
  } job_t;

  logic              clk_i;
  logic              arst_n_i;
  logic              sel_i;
  logic              cfg_req_i;
  acc_pkg::cfg_req_t cfg_i;
  logic              cfg_ack_o;
  acc_pkg::cfg_rsp_t cfg_rsp_o;
  logic              mem_req_o;
  acc_pkg::mem_req_t mem_o;
  logic              mem_ack_i;
  acc_pkg::mem_rsp_t mem_i;
  logic              busy_o;
  logic              evt_o;
  logic [1:0]        eng_ack;
  logic [1:0]        eng_evt;
  int                err_cnt;
  int                evt0_cnt;
  int                evt1_cnt;

  logic [31:0] mem [0:65535];
  logic [31:0] rng;
  int          lat;
  logic        timed_out;
  job_t        jobs [NUM_TESTS];

  acc_subsystem #(
    .LEN_W ( LEN_W )
  ) acc_subsystem_inst (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .sel_i     ( sel_i     ),
    .cfg_req_i ( cfg_req_i ),
    .cfg_i     ( cfg_i     ),
    .cfg_ack_o ( cfg_ack_o ),
    .cfg_rsp_o ( cfg_rsp_o ),
    .mem_req_o ( mem_req_o ),
    .mem_o     ( mem_o     ),
    .mem_ack_i ( mem_ack_i ),
    .mem_i     ( mem_i     ),
    .busy_o    ( busy_o    ),
    .evt_o     ( evt_o     )
  );

  // Per-engine view for the checker
  assign eng_ack = acc_subsystem_inst.eng_mem_ack;
  assign eng_evt = acc_subsystem_inst.eng_evt;

  tb_acc_checker check_inst (
    .clk_i      ( clk_i     ),
    .mem_req_i  ( mem_req_o ),
    .mem_i      ( mem_o     ),
    .mem_ack_i  ( mem_ack_i ),
    .eng_ack_i  ( eng_ack   ),
    .eng_evt_i  ( eng_evt   ),
    .evt_i      ( evt_o     ),
    .err_cnt_o  ( err_cnt   ),
    .evt0_cnt_o ( evt0_cnt  ),
    .evt1_cnt_o ( evt1_cnt  )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////////////////////////
  // Memory model, 1 to 4 cycle latency
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    #DRIVE_DLY;
    if (!arst_n_i) begin
      mem_ack_i = 1'b0;
      lat       = 0;
    end else if (mem_ack_i) begin
      if (!mem_req_o) mem_ack_i = 1'b0;
    end else if (mem_req_o) begin
      if (lat == 0) begin
        rng = xorshift32(rng);
        lat = 1 + int'(rng % 4);
      end
      lat = lat - 1;
      if (lat == 0) begin
        if (mem_o.wen) begin
          mem[mem_o.addr] = mem_o.wdata;
        end else begin
          mem_i.rdata = mem[mem_o.addr];
        end
        mem_ack_i = 1'b1;
      end
    end
  end

  task automatic cfg_access(input logic sel, input acc_pkg::acc_reg_e addr, input logic wen,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    rdata = '0;
    if (timed_out) return;
    sel_i       = sel;
    cfg_i.addr  = addr;
    cfg_i.wen   = wen;
    cfg_i.wdata = wdata;
    cfg_req_i   = 1'b1;
    n = 0;
    while (!cfg_ack_o && n < CFG_TIMEOUT) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      n++;
    end
    if (!cfg_ack_o) begin
      $display("timeout: engine %0d never acknowledged the config request", sel);
      timed_out = 1'b1;
      cfg_req_i = 1'b0;
      return;
    end
    rdata     = cfg_rsp_o.rdata;
    cfg_req_i = 1'b0;
    n = 0;
    while (cfg_ack_o && n < CFG_TIMEOUT) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      n++;
    end
    if (cfg_ack_o) begin
      $display("timeout: engine %0d held config ack after the request dropped", sel);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_events(input int want0, input int want1);
    int n;
    if (timed_out) return;
    n = 0;
    while ((evt0_cnt < want0 || evt1_cnt < want1) && n < RUN_TIMEOUT) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      n++;
    end
    if (evt0_cnt < want0 || evt1_cnt < want1) begin
      $display("timeout: engine event missing after %0d cycles", RUN_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  // Other engine, shifted regions, inverted factor
  function automatic job_t second_job(input job_t j);
    job_t k;
    k       = j;
    k.sel   = ~j.sel;
    k.src   = j.src + 16'h0080;
    k.dst   = j.dst + 16'h0080;
    k.param = ~j.param;
    k.dual  = 1'b0;
    return k;
  endfunction

  // Reference results from the current memory image
  task automatic push_expected(input job_t j);
    logic [15:0] a;
    logic [31:0] sum;
    sum = j.param;
    for (int i = 0; i < int'(j.len); i++) begin
      a = j.src + 16'(i);
      if (!j.sel) begin
        check_inst.expect_write(1'b0, j.dst + 16'(i), mem[a] * j.param);
      end else begin
        sum = sum + mem[a];
      end
    end
    if (j.sel && j.len != '0) check_inst.expect_write(1'b1, j.dst, sum);
  endtask

  task automatic program_job(input job_t j);
    logic [31:0] vals [4];
    logic [31:0] rd;
    vals[0] = {16'h0, j.src};
    vals[1] = {16'h0, j.dst};
    vals[2] = 32'(j.len);
    vals[3] = j.param;
    for (int r = 0; r < 4; r++) begin
      cfg_access(j.sel, acc_pkg::acc_reg_e'(r), 1'b1, vals[r], rd);
    end
    for (int r = 0; r < 4; r++) begin
      cfg_access(j.sel, acc_pkg::acc_reg_e'(r), 1'b0, '0, rd);
      if (!timed_out) check_inst.compare("cfg_rsp_o.rdata", rd, vals[r]);
    end
  endtask

  task automatic run_test(input int t);
    job_t        j;
    job_t        k;
    job_t        last;
    int          err0;
    logic [31:0] rd;
    j    = jobs[t];
    k    = second_job(j);
    last = j.dual ? k : j;
    err0 = err_cnt;
    check_inst.clear_events();
    push_expected(j);
    if (j.dual) push_expected(k);
    program_job(j);
    if (j.dual) program_job(k);
    cfg_access(j.sel, acc_pkg::REG_CTRL, 1'b1, 32'h1, rd);
    if (j.dual) cfg_access(k.sel, acc_pkg::REG_CTRL, 1'b1, 32'h1, rd);
    // Busy readback, then a setup write that must be dropped
    if (last.len >= 4 && !timed_out) begin
      cfg_access(last.sel, acc_pkg::REG_CTRL, 1'b0, '0, rd);
      check_inst.compare("cfg_rsp_o.rdata", rd, 32'h1);
      cfg_access(last.sel, acc_pkg::REG_PARAM, 1'b1, ~last.param, rd);
    end
    wait_events(int'(!j.sel || j.dual), int'(j.sel || j.dual));
    if (timed_out) return;
    // Top-level event follows the engine selected while the jobs run
    check_inst.check_events(int'(!j.sel || j.dual), int'(j.sel || j.dual), 1);
    check_inst.check_drained();
    cfg_access(j.sel, acc_pkg::REG_CTRL, 1'b0, '0, rd);
    check_inst.compare("cfg_rsp_o.rdata", rd, 32'h0);
    cfg_access(last.sel, acc_pkg::REG_PARAM, 1'b0, '0, rd);
    check_inst.compare("cfg_rsp_o.rdata", rd, last.param);
    check_inst.compare("busy_o", 32'(busy_o), 32'h0);
    $display("test %0d: sel %0d len %0d dual %0d, %0d errors",
             t, j.sel, j.len, j.dual, err_cnt - err0);
  endtask

  initial begin
    int t;
    sel_i     = 1'b0;
    cfg_req_i = 1'b0;
    cfg_i     = '0;
    mem_ack_i = 1'b0;
    mem_i     = '0;
    arst_n_i  = 1'b0;
    timed_out = 1'b0;
    lat       = 0;
    rng       = 32'h172fe17b;
    for (int a = 0; a < 65536; a++) begin
      rng    = xorshift32(rng);
      mem[a] = rng ^ 32'(a);
    end

    // sel, src, dst, len, param, dual
    jobs[0] = {1'b0, 16'h0100, 16'h1000, 8'd8, 32'h0000_0007, 1'b0};
    jobs[1] = {1'b1, 16'h0200, 16'h2000, 8'd5, 32'h1234_5678, 1'b0};
    jobs[2] = {1'b0, 16'h0300, 16'h3000, 8'd0, 32'h0000_0003, 1'b0};
    jobs[3] = {1'b1, 16'h0300, 16'h3100, 8'd0, 32'h0000_0009, 1'b0};
    jobs[4] = {1'b0, 16'h0400, 16'h4000, 8'd6, 32'h9e37_79b9, 1'b1};
    jobs[5] = {1'b1, 16'h0500, 16'h5000, 8'd4, 32'hffff_fff0, 1'b1};

    repeat (16) @(posedge clk_i);
    #DRIVE_DLY;
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #DRIVE_DLY;
    check_inst.compare("cfg_ack_o/mem_req_o/busy_o/evt_o",
                       32'({cfg_ack_o, mem_req_o, busy_o, evt_o}), 32'h0);

    for (t = 0; t < NUM_TESTS; t++) begin
      if (timed_out) break;
      run_test(t);
    end

    $display("%0d of %0d tests run, %0d errors, %0d timeouts",
             t, NUM_TESTS, err_cnt, int'(timed_out));
    if (err_cnt == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
